/* src/idiv_pkg.sv */
// shared widths and the divider register record for the mantissa-division datapath
package idiv_pkg;

    localparam int mant_w     = 53;   // mantissa incl. hidden bit
    localparam int quot_w     = 105;  // full quotient width
    localparam int shift_w    = 7;    // leading-zero count width
    localparam int stage_bits = 8;    // quotient bits per stage pass
    localparam int div_passes = 13;   // 8-bit passes after the single-bit pass

    // count reported when the quotient has no set bit
    localparam logic [shift_w-1:0] lz_none = 7'd104;

    // divider state, one record so the controller can use a v/r update style
    typedef struct packed {
        logic [div_passes+1:0] delay;              // one-hot pass sequencer
        logic [mant_w+stage_bits-1:0] divident;    // partial remainder plus new bits
        logic [mant_w-1:0] divisor;
        logic [quot_w-1:0] bits;                   // quotient being assembled
        logic [shift_w-1:0] lshift;                // index of first one bit
        logic lshift_rdy;                          // lshift already latched
        logic div_zero;
        logic exact;                               // remainder ended at zero
    } idiv53_registers;

    localparam idiv53_registers idiv53_r_reset = '{
        delay:      '0,
        divident:   '0,
        divisor:    '0,
        bits:       '0,
        lshift:     '0,
        lshift_rdy: 1'b0,
        div_zero:   1'b0,
        exact:      1'b0
    };

endpackage : idiv_pkg

/* src/idiv_result_if.sv */
// finished quotient from the divider controller to the normalizer, valid while rdy is high
`timescale 1ns/100ps

interface idiv_result_if;

    logic                          rdy;       // one-cycle done strobe
    logic [idiv_pkg::quot_w-1:0]   result;    // raw 105-bit quotient
    logic [idiv_pkg::shift_w-1:0]  lshift;    // leading zeros of result
    logic                          div_zero;
    logic                          exact;

    // divider side drives everything
    modport producer (
        output rdy,
        output result,
        output lshift,
        output div_zero,
        output exact
    );

    // normalizer side, no way to stall the producer
    modport consumer (
        input rdy,
        input result,
        input lshift,
        input div_zero,
        input exact
    );

endinterface : idiv_result_if

/* src/divstage53.sv */
// combinational radix-256 restoring division stage, used once per pass by the divider controller
`timescale 1ns/100ps

module divstage53 (
    input  logic                                                mux_ena_i,   // look for first one
    input  logic [idiv_pkg::stage_bits*idiv_pkg::shift_w-1:0]   muxind_i,    // index per step
    input  logic [idiv_pkg::mant_w+idiv_pkg::stage_bits-1:0]    divident_i,  // {rem, new bits}
    input  logic [idiv_pkg::mant_w-1:0]                         divisor_i,
    output logic [idiv_pkg::mant_w-1:0]                         dif_o,       // final remainder
    output logic [idiv_pkg::stage_bits-1:0]                     bits_o,      // msb first
    output logic [idiv_pkg::shift_w-1:0]                        muxind_o,
    output logic                                                muxind_rdy_o
);

    localparam int rem_w = idiv_pkg::mant_w;
    localparam int nbits = idiv_pkg::stage_bits;
    localparam int idx_w = idiv_pkg::shift_w;

    logic [rem_w:0] divisor_ext;   // one extra bit for the shifted compare

    assign divisor_ext = {1'b0, divisor_i};

    // eight chained shift-compare-subtract steps
    // the top rem_w bits of divident_i are the running remainder, the low
    // nbits bits are shifted in one per step
    always_comb begin : stage_proc
        logic [rem_w:0]   part;
        logic [rem_w-1:0] rem;
        logic             found;
        logic             q;

        rem = divident_i[rem_w+nbits-1:nbits];
        found = 1'b0;
        part = '0;
        q = 1'b0;
        bits_o = '0;
        muxind_o = '0;

        for (int k = 0; k < nbits; k++) begin
            part = {rem, divident_i[nbits-1-k]};    // shift in next bit
            q = (part >= divisor_ext);
            if (q) begin
                part = part - divisor_ext;          // restore skipped when q is 0
            end
            rem = part[rem_w-1:0];
            bits_o[nbits-1-k] = q;

            // first one in this pass picks its entry from the index table
            if (mux_ena_i && q && !found) begin
                found = 1'b1;
                muxind_o = muxind_i[(nbits-k)*idx_w-1 -: idx_w];
            end
        end

        dif_o = rem;
        muxind_rdy_o = found;
    end : stage_proc

endmodule : divstage53

/* src/idiv53.sv */
// iterative 53-bit mantissa divider controller, 14 stage passes per operation then a rdy strobe
`timescale 1ns/100ps

module idiv53 (
    input  logic                                                i_clk,
    input  logic                                                i_nrst,
    input  logic                                                ena_i,        // start pulse
    input  logic [idiv_pkg::mant_w-1:0]                         divident_i,
    input  logic [idiv_pkg::mant_w-1:0]                         divisor_i,
    idiv_result_if.producer                                     res,
    // towards divstage53
    output logic                                                mux_ena_o,
    output logic [idiv_pkg::stage_bits*idiv_pkg::shift_w-1:0]   muxind_o,
    output logic [idiv_pkg::mant_w+idiv_pkg::stage_bits-1:0]    divident_o,
    output logic [idiv_pkg::mant_w-1:0]                         divisor_o,
    // back from divstage53
    input  logic [idiv_pkg::mant_w-1:0]                         dif_i,
    input  logic [idiv_pkg::stage_bits-1:0]                     bits_i,
    input  logic [idiv_pkg::shift_w-1:0]                        muxind_i,
    input  logic                                                muxind_rdy_i
);

    localparam int nbits  = idiv_pkg::stage_bits;
    localparam int idx_w  = idiv_pkg::shift_w;
    localparam int passes = idiv_pkg::div_passes;
    localparam int qw     = idiv_pkg::quot_w;

    idiv_pkg::idiv53_registers r;
    idiv_pkg::idiv53_registers rin;

    always_comb begin : comb_proc
        idiv_pkg::idiv53_registers v;
        logic [nbits*idx_w-1:0]    vb_muxind;
        logic                      v_mux_ena;

        v = r;
        vb_muxind = '0;
        v_mux_ena = 1'b0;

        v.delay = {r.delay[passes:0], ena_i};    // one-hot walks one bit per clock

        if (ena_i) begin
            // a start mid-operation simply restarts
            v.delay = '0;
            v.delay[0] = 1'b1;                   // older pass bits are dropped
            v.divident = {{nbits{1'b0}}, divident_i};
            v.divisor = divisor_i;
            v.lshift_rdy = 1'b0;
            v.div_zero = (divisor_i == '0);
            v.exact = 1'b0;
        end else begin
            if (r.delay[0]) begin
                // single-bit pass, only the last step carries quotient msb
                v_mux_ena = ~r.lshift_rdy;
                v.divident = {dif_i, {nbits{1'b0}}};
                v.bits[qw-1] = bits_i[0];
            end

            for (int p = 1; p <= passes; p++) begin
                if (r.delay[p]) begin
                    v_mux_ena = ~r.lshift_rdy;
                    v.divident = {dif_i, {nbits{1'b0}}};
                    v.bits[(passes-p)*nbits +: nbits] = bits_i;
                    // table of leading-zero counts for this slice, msb first
                    for (int j = 0; j < nbits; j++) begin
                        vb_muxind[(nbits-1-j)*idx_w +: idx_w] = idx_w'((p-1)*nbits + j + 1);
                    end
                end
            end

            if (r.delay[passes] && (dif_i == '0)) begin
                v.exact = 1'b1;                  // nothing left over
            end

            // first set bit wins, later passes leave lshift alone
            if (!r.lshift_rdy) begin
                if (muxind_rdy_i) begin
                    v.lshift_rdy = 1'b1;
                    v.lshift = muxind_i;
                end else if (r.delay[passes]) begin
                    v.lshift_rdy = 1'b1;
                    v.lshift = idiv_pkg::lz_none;  // quotient is all zero
                end
            end
        end

        mux_ena_o = v_mux_ena;
        muxind_o = vb_muxind;
        rin = v;
    end : comb_proc

    // stage always sees the registered remainder
    assign divident_o = r.divident;
    assign divisor_o = r.divisor;

    assign res.rdy = r.delay[passes+1];
    assign res.result = r.bits;
    assign res.lshift = r.lshift;
    assign res.div_zero = r.div_zero;
    assign res.exact = r.exact;

    always_ff @(posedge i_clk or negedge i_nrst) begin : reg_proc
        if (!i_nrst) begin
            r <= idiv_pkg::idiv53_r_reset;
        end else begin
            r <= rin;
        end
    end : reg_proc

endmodule : idiv53

/* src/mant_normalize.sv */
// registered quotient normalizer, turns the raw divider result into mantissa, guard and sticky
`timescale 1ns/100ps

module mant_normalize (
    input  logic                            i_clk,
    input  logic                            i_nrst,
    idiv_result_if.consumer                 res,
    output logic                            valid_o,
    output logic [idiv_pkg::mant_w-1:0]     quot_o,
    output logic                            guard_o,
    output logic                            sticky_o,
    output logic [idiv_pkg::shift_w-1:0]    lshift_o,
    output logic                            div_zero_o,
    output logic                            exact_o
);

    localparam int qw = idiv_pkg::quot_w;
    localparam int mw = idiv_pkg::mant_w;

    logic [qw-1:0] shifted;    // leading one moved to the top
    logic          guard_nxt;
    logic          sticky_nxt;

    assign shifted = res.result << res.lshift;
    assign guard_nxt = shifted[qw-mw-1];

    // leftover quotient bits, or a nonzero remainder beyond them
    assign sticky_nxt = (|shifted[qw-mw-2:0]) | ~res.exact;

    // control and flags
    always_ff @(posedge i_clk or negedge i_nrst) begin : flag_proc
        if (!i_nrst) begin
            valid_o <= 1'b0;
            guard_o <= 1'b0;
            sticky_o <= 1'b0;
            div_zero_o <= 1'b0;
            exact_o <= 1'b0;
        end else begin
            valid_o <= res.rdy;    // one-cycle pulse
            if (res.rdy) begin
                guard_o <= guard_nxt;
                sticky_o <= sticky_nxt;
                div_zero_o <= res.div_zero;
                exact_o <= res.exact;
            end
        end
    end : flag_proc

    // mantissa and shift count, held until the next result
    always_ff @(posedge i_clk) begin : data_proc
        if (res.rdy) begin
            quot_o <= shifted[qw-1 -: mw];
            lshift_o <= res.lshift;    // exponent logic subtracts this
        end
    end : data_proc

endmodule : mant_normalize

/* src/mant_div_unit.sv */
// top level of the mantissa-division datapath, start pulse in and valid pulse out 16 clocks later
`timescale 1ns/100ps

module mant_div_unit (
    input  logic                            i_clk,
    input  logic                            i_nrst,
    input  logic                            start_i,
    input  logic [idiv_pkg::mant_w-1:0]     dividend_i,
    input  logic [idiv_pkg::mant_w-1:0]     divisor_i,
    output logic                            valid_o,
    output logic [idiv_pkg::mant_w-1:0]     quot_o,
    output logic                            guard_o,
    output logic                            sticky_o,
    output logic [idiv_pkg::shift_w-1:0]    lshift_o,
    output logic                            div_zero_o,
    output logic                            exact_o
);

    // controller to stage
    logic                                                 stage_mux_ena;
    logic [idiv_pkg::stage_bits*idiv_pkg::shift_w-1:0]    stage_muxind_tbl;
    logic [idiv_pkg::mant_w+idiv_pkg::stage_bits-1:0]     stage_divident;
    logic [idiv_pkg::mant_w-1:0]                          stage_divisor;
    // stage to controller
    logic [idiv_pkg::mant_w-1:0]                          stage_dif;
    logic [idiv_pkg::stage_bits-1:0]                      stage_bits;
    logic [idiv_pkg::shift_w-1:0]                         stage_muxind;
    logic                                                 stage_muxind_rdy;

    idiv_result_if div_res ();

    idiv53 divider0 (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .ena_i        (start_i),
        .divident_i   (dividend_i),
        .divisor_i    (divisor_i),
        .res          (div_res.producer),
        .mux_ena_o    (stage_mux_ena),
        .muxind_o     (stage_muxind_tbl),
        .divident_o   (stage_divident),
        .divisor_o    (stage_divisor),
        .dif_i        (stage_dif),
        .bits_i       (stage_bits),
        .muxind_i     (stage_muxind),
        .muxind_rdy_i (stage_muxind_rdy)
    );

    divstage53 stage0 (
        .mux_ena_i    (stage_mux_ena),
        .muxind_i     (stage_muxind_tbl),
        .divident_i   (stage_divident),
        .divisor_i    (stage_divisor),
        .dif_o        (stage_dif),
        .bits_o       (stage_bits),
        .muxind_o     (stage_muxind),
        .muxind_rdy_o (stage_muxind_rdy)
    );

    mant_normalize norm0 (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .res          (div_res.consumer),
        .valid_o      (valid_o),
        .quot_o       (quot_o),
        .guard_o      (guard_o),
        .sticky_o     (sticky_o),
        .lshift_o     (lshift_o),
        .div_zero_o   (div_zero_o),
        .exact_o      (exact_o)
    );

endmodule : mant_div_unit

/* test/mant_div_assertions.sv */
// protocol checks for the mantissa-division unit, attached to the top level by the bind below
`timescale 1ns/100ps

module mant_div_assertions (
    input logic i_clk,
    input logic i_nrst,
    input logic start_i,
    input logic valid_i
);

    localparam int latency = 16;    // start edge to the edge that sees valid

    logic [4:0] since_start;    // edges since the last sampled start
    logic       busy;
    int         fail_count = 0;    // failed protocol checks so far

    // tracks one operation from its start edge up to its valid edge
    always_ff @(posedge i_clk or negedge i_nrst) begin : track_proc
        if (!i_nrst) begin
            busy <= 1'b0;
            since_start <= '0;
        end else if (start_i) begin
            busy <= 1'b1;
            since_start <= 5'd1;
        end else if (busy) begin
            since_start <= since_start + 5'd1;
            if (since_start == 5'(latency)) begin
                busy <= 1'b0;
            end
        end
    end : track_proc

    valid_single_pulse: assert property (@(posedge i_clk) disable iff (!i_nrst)
        valid_i |=> !valid_i)
        else begin
            $error("valid_o stayed high for two cycles");
            fail_count++;
        end

    // a new start is fine on the edge that sees the previous valid
    no_start_while_busy: assert property (@(posedge i_clk) disable iff (!i_nrst)
        start_i |-> !(busy && (since_start < 5'(latency))))
        else begin
            $error("start_i raised while a division was running");
            fail_count++;
        end

    valid_on_time: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (busy && (since_start == 5'(latency))) |-> valid_i)
        else begin
            $error("valid_o missing 16 cycles after start_i");
            fail_count++;
        end

    valid_not_stray: assert property (@(posedge i_clk) disable iff (!i_nrst)
        valid_i |-> (busy && (since_start == 5'(latency))))
        else begin
            $error("valid_o raised without a start 16 cycles earlier");
            fail_count++;
        end

endmodule : mant_div_assertions

bind mant_div_unit mant_div_assertions protocol_checks (
    .i_clk   (i_clk),
    .i_nrst  (i_nrst),
    .start_i (start_i),
    .valid_i (valid_o)
);

/* test/mant_div_tb.sv */
// testbench for the mantissa-division unit, replays the vectors of test/mant_div_tests.txt
`timescale 1ns/100ps

module mant_div_tb;

    localparam int mw         = idiv_pkg::mant_w;
    localparam int sw         = idiv_pkg::shift_w;
    localparam int latency    = 16;    // edges from start edge to valid, sampling edge included
    localparam int wait_limit = 40;

    logic          i_clk;
    logic          i_nrst;
    logic          start;
    logic [mw-1:0] dividend;
    logic [mw-1:0] divisor;
    logic          valid;
    logic [mw-1:0] quot;
    logic          guard;
    logic          sticky;
    logic [sw-1:0] lshift;
    logic          div_zero;
    logic          exact;

    int n_checks;
    int n_errors;
    int n_ops;

    mant_div_unit dut_i (
        .i_clk      (i_clk),
        .i_nrst     (i_nrst),
        .start_i    (start),
        .dividend_i (dividend),
        .divisor_i  (divisor),
        .valid_o    (valid),
        .quot_o     (quot),
        .guard_o    (guard),
        .sticky_o   (sticky),
        .lshift_o   (lshift),
        .div_zero_o (div_zero),
        .exact_o    (exact)
    );

    always #4 i_clk = ~i_clk;    // 8 ns period

    task automatic check_value(input logic [8*32-1:0] test_name, input string field,
                               input logic [63:0] expected, input logic [63:0] actual);
        n_checks++;
        assert (actual === expected) else begin
            $display("FAILED %0s %0s expected %h actual %h", test_name, field, expected, actual);
            n_errors++;
        end
    endtask

    // reset held low for 8 cycles, released just after an edge
    task automatic reset_dut();
        i_nrst = 1'b0;
        repeat (8) @(posedge i_clk);
        #1;
        i_nrst = 1'b1;
    endtask

    // nothing may come out before the first start
    task automatic check_idle();
        repeat (4) begin
            @(posedge i_clk);
            #1;
            check_value("after_reset", "valid", 64'd0, 64'(valid));
        end
        check_value("after_reset", "guard", 64'd0, 64'(guard));
        check_value("after_reset", "sticky", 64'd0, 64'(sticky));
        check_value("after_reset", "div_zero", 64'd0, 64'(div_zero));
        check_value("after_reset", "exact", 64'd0, 64'(exact));
    endtask

    // called 1 ns after an edge, returns 1 ns after the edge that shows valid
    task automatic run_operation(input logic [mw-1:0] a, input logic [mw-1:0] b,
                                 output int cycles, output bit timed_out);
        bit seen;

        seen = 1'b0;
        cycles = 0;
        start = 1'b1;
        dividend = a;
        divisor = b;
        while (!seen && (cycles < wait_limit)) begin
            @(posedge i_clk);
            #1;
            start = 1'b0;    // one-cycle pulse
            cycles++;
            seen = valid;
        end
        timed_out = !seen;
    endtask

    initial begin : main_proc
        int               fd;
        int               n_fields;
        int               cycles;
        bit               timed_out;
        bit               stop;
        logic [8*200-1:0] line_buf;
        logic [8*32-1:0]  test_name;
        logic [mw-1:0]    op_a;
        logic [mw-1:0]    op_b;
        logic [mw-1:0]    exp_quot;
        logic             exp_guard;
        logic             exp_sticky;
        logic [sw-1:0]    exp_lshift;
        logic             exp_exact;
        logic             exp_dz;

        i_clk = 1'b0;
        i_nrst = 1'b0;
        start = 1'b0;
        dividend = '0;
        divisor = '0;
        n_checks = 0;
        n_errors = 0;
        n_ops = 0;
        stop = 1'b0;

        reset_dut();
        check_idle();

        fd = $fopen("test/mant_div_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the test vector file");
            n_errors++;
        end else begin
            while (!stop && ($fgets(line_buf, fd) > 0)) begin
                // comment and blank lines never yield all nine fields
                n_fields = $sscanf(line_buf, "%s %h %h %h %h %h %h %h %h", test_name,
                                   op_a, op_b, exp_quot, exp_guard, exp_sticky,
                                   exp_lshift, exp_exact, exp_dz);
                if (n_fields == 9) begin
                    n_ops++;
                    run_operation(op_a, op_b, cycles, timed_out);    // back to back
                    if (timed_out) begin
                        $display("timeout, no valid_o within %0d cycles in test %0s",
                                 wait_limit, test_name);
                        n_errors++;
                        stop = 1'b1;
                    end else begin
                        check_value(test_name, "latency", 64'(latency), 64'(cycles));
                        check_value(test_name, "quot", 64'(exp_quot), 64'(quot));
                        check_value(test_name, "guard", 64'(exp_guard), 64'(guard));
                        check_value(test_name, "sticky", 64'(exp_sticky), 64'(sticky));
                        check_value(test_name, "lshift", 64'(exp_lshift), 64'(lshift));
                        check_value(test_name, "exact", 64'(exp_exact), 64'(exact));
                        check_value(test_name, "div_zero", 64'(exp_dz), 64'(div_zero));
                    end
                end
            end
            $fclose(fd);
            if (n_ops == 0) begin
                $display("no test vectors were found in the vector file");
                n_errors++;
            end
        end

        n_errors += dut_i.protocol_checks.fail_count;    // bound protocol checker

        $display("operations: %0d, checks: %0d, errors: %0d", n_ops, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end : main_proc

endmodule : mant_div_tb

/* verilog.f */
src/idiv_pkg.sv
src/idiv_result_if.sv
src/divstage53.sv
src/idiv53.sv
src/mant_normalize.sv
src/mant_div_unit.sv
test/mant_div_assertions.sv
test/mant_div_tb.sv

/* test/mant_div_tests.txt */
# name dividend divisor quot guard sticky lshift exact div_zero
# all values hex, quotient taken as floor(dividend * 2^104 / divisor) then normalized
eq_min         10000000000000 10000000000000 10000000000000 0 0 0  1 0
eq_max         1FFFFFFFFFFFFF 1FFFFFFFFFFFFF 10000000000000 0 0 0  1 0
eq_mid         18000000000000 18000000000000 10000000000000 0 0 0  1 0
small_2_3      10000000000000 18000000000000 15555555555555 0 1 1  0 0
small_3_4      12000000000000 18000000000000 18000000000000 0 0 1  1 0
small_4_7      10000000000000 1C000000000000 12492492492492 0 1 1  0 0
min_over_max   10000000000000 1FFFFFFFFFFFFF 10000000000000 1 1 1  0 0
inexact_7_6    1C000000000000 18000000000000 12AAAAAAAAAAAA 1 1 0  0 0
exact_3_2      1B000000000000 12000000000000 18000000000000 0 0 0  1 0
max_over_min   1FFFFFFFFFFFFF 10000000000000 1FFFFFFFFFFFFF 0 0 0  1 0
div_by_zero    10000000000000 00000000000000 1FFFFFFFFFFFFF 1 1 0  1 1
zero_dividend  00000000000000 10000000000000 00000000000000 0 0 68 1 0
eq_after_zero  10000000000000 10000000000000 10000000000000 0 0 0  1 0
small_2_3_rep  10000000000000 18000000000000 15555555555555 0 1 1  0 0
